/* source/icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// set index bits, 16 sets
`define INDEX_WIDTH 4

// word-in-line bits, four words per line
`define OFFSET_WIDTH 2

// two ways; LRU bit and way select are built for two
`define WAYS 2

// returned in place of a flushed fetch
`define NOP_INST 32'h0340_0000

`endif

/* source/icache_pkg.sv */
`default_nettype none

`include "icache_config.svh"

package icache_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////

    localparam int TAG_W      = 32 - `INDEX_WIDTH - `OFFSET_WIDTH - 2;
    localparam int LINE_WORDS = 1 << `OFFSET_WIDTH;

    typedef logic [31:0] word_t;                  // one instruction
    typedef word_t [LINE_WORDS-1:0] line_t;       // word 0 in the low bits

    typedef logic [`INDEX_WIDTH-1:0] index_t;

    // byte address as seen by the cache
    typedef struct packed {
        logic [TAG_W-1:0]         tag;
        index_t                   index;
        logic [`OFFSET_WIDTH-1:0] offset;         // word within line
        logic [1:0]               byte_sel;       // always zero for fetches
    } fetch_addr_t;

    //////////////////////////////
    // array entries and control
    //////////////////////////////

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tagv_t;

    // from the pipeline
    typedef struct packed {
        logic stall;                              // fetch stage cannot take a word
        logic flush;                              // drop the fetch in lookup
    } pipe_ctrl_t;

    // one bit per way, for hits and write enables
    typedef logic [`WAYS-1:0] way_mask_t;

endpackage

`default_nettype wire

/* source/icache_set_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_set_ram #(
    parameter type entry_t        = logic [31:0],
    parameter bit  CLEAR_ON_RESET = 1'b0
) (
    input  wire logic                clk,
    input  wire logic                rstn,
    input  wire icache_pkg::index_t  rd_index,
    input  wire logic                we,
    input  wire icache_pkg::index_t  wr_index,
    input  wire entry_t              wr_data,
    output entry_t                   rd_data
);
    import icache_pkg::*;

    localparam int SETS = 1 << $bits(index_t);

    entry_t mem [SETS];

    generate
        if (CLEAR_ON_RESET) begin : g_clear
            // tag arrays start all invalid
            always_ff @(posedge clk or negedge rstn) begin
                if (!rstn) begin
                    for (int i = 0; i < SETS; i++) begin
                        mem[i] <= '0;
                    end
                end else if (we) begin
                    mem[wr_index] <= wr_data;
                end
            end
        end else begin : g_plain
            always_ff @(posedge clk) begin
                if (we) mem[wr_index] <= wr_data;
            end
        end
    endgenerate

    // registered read, new data wins when both hit the same set
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_data <= '0;
        end else if (we && (wr_index == rd_index)) begin
            rd_data <= wr_data;   // refill seen by a lookup of the same set
        end else begin
            rd_data <= mem[rd_index];
        end
    end

endmodule

`default_nettype wire

/* source/icache_req_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_req_buf (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    buf_we,
    input  wire icache_pkg::fetch_addr_t req_addr,
    input  wire logic                    req_op,
    input  wire logic                    refill_we,
    input  wire icache_pkg::line_t       refill_line,
    output icache_pkg::fetch_addr_t      buf_addr,
    output logic                         buf_op,
    output icache_pkg::line_t            buf_line,
    output icache_pkg::index_t           array_index
);
    import icache_pkg::*;

    fetch_addr_t addr_q;
    logic        op_q;
    line_t       line_q;

    // request under lookup
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_q <= '0;
            op_q   <= 1'b0;
        end else if (buf_we) begin
            addr_q <= req_addr;
            op_q   <= req_op;
        end
    end

    // last refilled line, kept for the replace state
    always_ff @(posedge clk) begin
        if (refill_we) line_q <= refill_line;
    end

    assign buf_addr = addr_q;
    assign buf_op   = op_q;

    // memory line passes straight through in the data_ok cycle
    assign buf_line = refill_we ? refill_line : line_q;

    // arrays follow the incoming request, else hold the set in lookup
    assign array_index = buf_we ? req_addr.index : addr_q.index;

endmodule

`default_nettype wire

/* source/icache_lru.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_lru (
    input  wire logic               clk,
    input  wire logic               rstn,
    input  wire icache_pkg::index_t index,
    input  wire logic               use0,
    input  wire logic               use1,
    output logic                    victim
);
    import icache_pkg::*;

    localparam int SETS = 1 << $bits(index_t);

    logic [SETS-1:0] lru_bits;   // 1 means way 1 is least recent

    assign victim = lru_bits[index];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_bits <= '0;
        end else if (use0) begin
            lru_bits[index] <= 1'b1;   // way 0 just used
        end else if (use1) begin
            lru_bits[index] <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/icache_hit_select.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_hit_select (
    input  wire icache_pkg::fetch_addr_t buf_addr,
    input  wire icache_pkg::tagv_t       tagv0,
    input  wire icache_pkg::tagv_t       tagv1,
    input  wire icache_pkg::line_t       line0,
    input  wire icache_pkg::line_t       line1,
    input  wire icache_pkg::line_t       refill_line,
    input  wire logic                    choose_way,
    input  wire logic                    choose_return,
    input  wire logic                    send_nop,
    output icache_pkg::way_mask_t        hit,
    output icache_pkg::word_t            inst
);
    import icache_pkg::*;

    line_t sel_line;
    word_t sel_word;

    //////////////////////////////
    // tag compare
    //////////////////////////////

    assign hit[0] = tagv0.valid && (tagv0.tag == buf_addr.tag);
    assign hit[1] = tagv1.valid && (tagv1.tag == buf_addr.tag);

    //////////////////////////////
    // word select
    //////////////////////////////

    // forwarded line beats the arrays
    always_comb begin
        if (choose_return) begin
            sel_line = refill_line;
        end else if (choose_way) begin
            sel_line = line1;
        end else begin
            sel_line = line0;
        end
    end

    assign sel_word = sel_line[buf_addr.offset];

    assign inst = send_nop ? word_t'(`NOP_INST) : sel_word;   // flushed fetch

endmodule

`default_nettype wire

/* source/icache_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl_fsm (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   req_valid,
    input  wire logic                   req_op,
    input  wire icache_pkg::pipe_ctrl_t ctrl,
    output logic                        req_ready,
    output logic                        inst_valid,
    output logic                        mem_req,
    input  wire logic                   mem_addr_ok,
    input  wire logic                   mem_data_ok,
    output logic                        buf_we,
    output logic                        refill_we,
    input  wire logic                   buf_op,
    input  wire icache_pkg::way_mask_t  hit,
    input  wire logic                   victim,
    output logic                        use0,
    output logic                        use1,
    output icache_pkg::way_mask_t       data_we,
    output logic                        inv_set,
    output logic                        choose_way,
    output logic                        choose_return,
    output logic                        send_nop
);
    import icache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS_REQ,
        S_MISS_WAIT,
        S_REPLACE,
        S_OP,
        S_FLUSH
    } state_t;

    state_t state;
    state_t next_state;
    state_t accept_state;   // where a newly accepted request goes
    logic   rstn_q;
    logic   ready_int;
    logic   accept;

    // ready stays low for one cycle after reset release
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) rstn_q <= 1'b0;
        else rstn_q <= 1'b1;
    end

    assign req_ready = ready_int & rstn_q;
    assign accept    = req_valid & req_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) state <= S_IDLE;
        else state <= next_state;
    end

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        if (!accept) accept_state = S_IDLE;
        else if (req_op) accept_state = S_OP;
        else accept_state = S_LOOKUP;
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE:   next_state = accept_state;
            S_LOOKUP: begin
                if (ctrl.flush) begin
                    next_state = S_FLUSH;
                end else if (hit == '0) begin
                    next_state = mem_addr_ok ? S_MISS_WAIT : S_MISS_REQ;
                end else begin
                    next_state = accept_state;   // hit, keep streaming
                end
            end
            S_MISS_REQ: begin
                if (mem_addr_ok) next_state = S_MISS_WAIT;
            end
            S_MISS_WAIT: begin
                if (mem_data_ok) begin
                    next_state = ctrl.stall ? S_REPLACE : accept_state;
                end
            end
            S_REPLACE: begin
                if (!ctrl.stall) next_state = accept_state;
            end
            S_OP:     next_state = S_IDLE;
            S_FLUSH:  next_state = accept_state;
            default:  next_state = S_IDLE;
        endcase
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    always_comb begin
        ready_int     = 1'b0;
        inst_valid    = 1'b0;
        mem_req       = 1'b0;
        buf_we        = 1'b0;
        refill_we     = 1'b0;
        use0          = 1'b0;
        use1          = 1'b0;
        data_we       = '0;
        inv_set       = 1'b0;
        choose_way    = 1'b0;
        choose_return = 1'b0;
        send_nop      = 1'b0;
        case (state)
            S_IDLE: begin
                ready_int = 1'b1;
                buf_we    = accept;
            end
            S_LOOKUP: begin
                if (ctrl.flush) begin
                    inst_valid = 1'b1;
                    send_nop   = 1'b1;
                end else if (hit != '0) begin
                    inst_valid = 1'b1;
                    ready_int  = 1'b1;
                    buf_we     = accept;
                    choose_way = ~hit[0];   // way 0 first
                    use0       = hit[0];
                    use1       = ~hit[0];
                end else begin
                    mem_req = 1'b1;         // miss, ask right away
                end
            end
            S_MISS_REQ: mem_req = 1'b1;
            S_MISS_WAIT: begin
                if (mem_data_ok) begin
                    refill_we     = 1'b1;
                    data_we       = way_mask_t'(1) << victim;
                    use0          = ~victim;
                    use1          = victim;
                    choose_return = 1'b1;   // forward from the memory line
                    inst_valid    = 1'b1;
                    ready_int     = ~ctrl.stall;
                    buf_we        = accept;
                end
            end
            S_REPLACE: begin
                choose_return = 1'b1;       // buffered line now
                inst_valid    = 1'b1;
                ready_int     = ~ctrl.stall;
                buf_we        = accept;
            end
            S_OP: inv_set = buf_op;
            S_FLUSH: begin
                ready_int = 1'b1;
                buf_we    = accept;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_top (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    // pipeline side
    input  wire logic                    req_valid,
    input  wire icache_pkg::fetch_addr_t req_addr,
    input  wire logic                    req_op,
    input  wire icache_pkg::pipe_ctrl_t  ctrl,
    output logic                         req_ready,
    output logic                         inst_valid,
    output icache_pkg::word_t            inst,
    // memory side
    output logic                         mem_req,
    output icache_pkg::fetch_addr_t      mem_addr,
    input  wire logic                    mem_addr_ok,
    input  wire logic                    mem_data_ok,
    input  wire icache_pkg::line_t       mem_line
);
    import icache_pkg::*;

    logic        buf_we;
    logic        refill_we;
    fetch_addr_t buf_addr;
    logic        buf_op;
    line_t       buf_line;
    index_t      array_index;
    way_mask_t   hit;
    logic        victim;
    logic        use0;
    logic        use1;
    way_mask_t   data_we;
    way_mask_t   tagv_we;
    logic        inv_set;
    logic        choose_way;
    logic        choose_return;
    logic        send_nop;
    tagv_t       tagv_wdata;
    tagv_t       tagv_rd [`WAYS];
    line_t       line_rd [`WAYS];

    // cache op writes invalid to both ways of the set
    assign tagv_we    = data_we | {`WAYS{inv_set}};
    assign tagv_wdata = inv_set ? tagv_t'('0) : tagv_t'{valid: 1'b1, tag: buf_addr.tag};

    assign mem_addr = fetch_addr_t'{tag: buf_addr.tag, index: buf_addr.index,
                                    offset: '0, byte_sel: '0};   // line aligned

    icache_ctrl_fsm ctrl_fsm_inst (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .req_op(req_op), .ctrl(ctrl),
        .req_ready(req_ready), .inst_valid(inst_valid),
        .mem_req(mem_req), .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .buf_we(buf_we), .refill_we(refill_we), .buf_op(buf_op),
        .hit(hit), .victim(victim), .use0(use0), .use1(use1),
        .data_we(data_we), .inv_set(inv_set),
        .choose_way(choose_way), .choose_return(choose_return), .send_nop(send_nop)
    );

    icache_req_buf req_buf_inst (
        .clk(clk), .rstn(rstn),
        .buf_we(buf_we), .req_addr(req_addr), .req_op(req_op),
        .refill_we(refill_we), .refill_line(mem_line),
        .buf_addr(buf_addr), .buf_op(buf_op), .buf_line(buf_line),
        .array_index(array_index)
    );

    icache_lru lru_inst (
        .clk(clk), .rstn(rstn),
        .index(buf_addr.index), .use0(use0), .use1(use1), .victim(victim)
    );

    // buf_line carries the memory line during refill, the stored one after
    icache_hit_select hit_select_inst (
        .buf_addr(buf_addr),
        .tagv0(tagv_rd[0]), .tagv1(tagv_rd[1]),
        .line0(line_rd[0]), .line1(line_rd[1]),
        .refill_line(buf_line),
        .choose_way(choose_way), .choose_return(choose_return), .send_nop(send_nop),
        .hit(hit), .inst(inst)
    );

    //////////////////////////////
    // per-way arrays
    //////////////////////////////

    for (genvar w = 0; w < `WAYS; w++) begin : g_way
        icache_set_ram #(.entry_t(tagv_t), .CLEAR_ON_RESET(1'b1)) tagv_ram_inst (
            .clk(clk), .rstn(rstn),
            .rd_index(array_index), .we(tagv_we[w]), .wr_index(buf_addr.index),
            .wr_data(tagv_wdata), .rd_data(tagv_rd[w])
        );

        icache_set_ram #(.entry_t(line_t), .CLEAR_ON_RESET(1'b0)) data_ram_inst (
            .clk(clk), .rstn(rstn),
            .rd_index(array_index), .we(data_we[w]), .wr_index(buf_addr.index),
            .wr_data(mem_line), .rd_data(line_rd[w])
        );
    end

endmodule

`default_nettype wire

/* verification/icache_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model #(
    parameter logic [31:0] PATTERN = 32'h5a5a_c3c3
) (
    input  wire logic                    clk,
    input  wire logic                    rstn,
    input  wire logic                    mem_req,
    input  wire icache_pkg::fetch_addr_t mem_addr,
    output logic                         mem_addr_ok,
    output logic                         mem_data_ok,
    output icache_pkg::line_t            mem_line,
    output int                           req_count
);
    import icache_pkg::*;

    int          phase;        // 0 idle, 1 request seen, 2 waiting for data
    int          wait_cnt;
    logic [31:0] line_base;

    // outputs change on the falling edge only
    always @(negedge clk or negedge rstn) begin
        if (!rstn) begin
            phase       <= 0;
            wait_cnt    <= 0;
            line_base   <= '0;
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_line    <= '0;
            req_count   <= 0;
        end else begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            case (phase)
                0: if (mem_req) phase <= 1;
                1: begin
                    mem_addr_ok <= 1'b1;          // two cycles after mem_req rose
                    line_base   <= mem_addr;
                    req_count   <= req_count + 1;
                    wait_cnt    <= 0;
                    phase       <= 2;
                end
                default: begin
                    if (wait_cnt == 3) begin
                        mem_data_ok <= 1'b1;      // four cycles after addr_ok
                        for (int i = 0; i < LINE_WORDS; i++) begin
                            mem_line[i] <= ((line_base >> 2) + 32'(i)) ^ PATTERN;
                        end
                        phase <= 0;
                    end else begin
                        wait_cnt <= wait_cnt + 1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verification/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "icache_config.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int          N       = 40;
    localparam int          LIMIT   = N * 20 + 16 + 10;   // cycles
    localparam logic [31:0] PATTERN = 32'h5a5a_c3c3;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    fetch_addr_t req_addr;
    logic        req_op;
    pipe_ctrl_t  ctrl;
    logic        req_ready;
    logic        inst_valid;
    word_t       inst;
    logic        mem_req;
    fetch_addr_t mem_addr;
    logic        mem_addr_ok;
    logic        mem_data_ok;
    line_t       mem_line;
    int          req_count;

    // stimulus table
    logic [31:0] tbl_addr [N];
    bit          tbl_op [N];
    bit          tbl_flush [N];
    bit          tbl_stall [N];
    int          tbl_miss [N];     // -1 when only the model knows

    // reference cache
    bit          m_valid [2][16];
    logic [23:0] m_tag [2][16];
    bit          m_lru [16];       // way to replace next
    int          model_misses;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] seed;

    icache_top icache_top_inst (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .req_addr(req_addr), .req_op(req_op), .ctrl(ctrl),
        .req_ready(req_ready), .inst_valid(inst_valid), .inst(inst),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .mem_line(mem_line)
    );

    icache_mem_model #(.PATTERN(PATTERN)) mem_model_inst (
        .clk(clk), .rstn(rstn), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .mem_line(mem_line), .req_count(req_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: the DUT stopped answering after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {17'd0, seed[30:16]};
    endfunction

    function automatic logic [31:0] make_addr(int tag, int index, int offset);
        return {24'(tag), 4'(index), 2'(offset), 2'b00};
    endfunction

    function automatic word_t expected_word(logic [31:0] a);
        return (a >> 2) ^ PATTERN;
    endfunction

    ////////////////////////////////
    // reference cache model
    ////////////////////////////////

    function automatic bit model_access(logic [31:0] a);
        int idx;
        idx = int'(a[7:4]);
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][idx] && m_tag[w][idx] == a[31:8]) begin
                m_lru[idx] = (w == 0);     // other way is now older
                return 1'b0;
            end
        end
        m_valid[m_lru[idx]][idx] = 1'b1;
        m_tag[m_lru[idx]][idx]   = a[31:8];
        m_lru[idx]               = ~m_lru[idx];
        model_misses++;
        return 1'b1;
    endfunction

    task automatic add_entry(int i, logic [31:0] a, bit op, bit fl, bit st, int miss);
        tbl_addr[i]  = a;
        tbl_op[i]    = op;
        tbl_flush[i] = fl;
        tbl_stall[i] = st;
        tbl_miss[i]  = miss;
    endtask

    task automatic build_table();
        logic [31:0] r;
        // set 3 holds lines A (tag 1), B (tag 2), C (tag 3)
        add_entry(0,  make_addr(1, 3, 1), 0, 0, 0, 1);    // cold miss
        add_entry(1,  make_addr(1, 3, 2), 0, 0, 0, 0);
        add_entry(2,  make_addr(2, 3, 0), 0, 0, 0, 1);
        add_entry(3,  make_addr(1, 3, 3), 0, 0, 0, 0);
        add_entry(4,  make_addr(3, 3, 1), 0, 0, 0, 1);    // C evicts B
        add_entry(5,  make_addr(1, 3, 0), 0, 0, 0, 0);
        add_entry(6,  make_addr(2, 3, 2), 0, 0, 0, 1);
        add_entry(7,  make_addr(3, 3, 0), 0, 1, 0, -1);   // flushed lookup
        add_entry(8,  make_addr(1, 3, 1), 0, 0, 0, 0);
        add_entry(9,  make_addr(1, 3, 0), 1, 0, 0, -1);   // invalidate set 3
        add_entry(10, make_addr(1, 3, 1), 0, 0, 0, 1);
        add_entry(11, make_addr(2, 3, 3), 0, 0, 0, 1);
        add_entry(12, make_addr(7, 5, 2), 0, 0, 1, 1);    // stall at refill
        add_entry(13, make_addr(7, 5, 3), 0, 0, 0, 0);
        add_entry(14, make_addr(8, 5, 0), 0, 0, 1, 1);
        add_entry(15, make_addr(7, 5, 1), 0, 0, 0, 0);
        for (int i = 16; i < N; i++) begin
            r = lcg_next();
            add_entry(i, make_addr(int'(r[1:0]) + 1, r[2] ? 5 : 3, int'(r[4:3])),
                      0, 0, r[7] & r[8], -1);
        end
    endtask

    task automatic report(string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic step();
        @(negedge clk);
        #1;
    endtask

    ////////////////////////////////
    // one table entry
    ////////////////////////////////

    task automatic run_entry(int i);
        int latency;
        int count_before;
        bit miss;
        @(negedge clk);
        req_valid  = 1'b1;
        req_addr   = fetch_addr_t'(tbl_addr[i]);
        req_op     = tbl_op[i];
        ctrl.stall = tbl_stall[i];
        ctrl.flush = tbl_flush[i];     // held through the whole lookup cycle
        #1;
        while (!req_ready) step();
        count_before = req_count;
        @(negedge clk);                // accepted at the rising edge before
        req_valid  = 1'b0;
        req_op     = 1'b0;
        #1;
        latency = 1;
        checks++;
        if (tbl_op[i]) begin
            for (int w = 0; w < 2; w++) m_valid[w][int'(tbl_addr[i][7:4])] = 1'b0;
            while (!req_ready) begin
                if (inst_valid) report($sformatf("entry %0d: inst_valid on cache op", i));
                step();
            end
            if (inst_valid) report($sformatf("entry %0d: inst_valid on cache op", i));
        end else if (tbl_flush[i]) begin
            if (!inst_valid || inst !== `NOP_INST)
                report($sformatf("entry %0d: flush gave %h valid %b", i, inst, inst_valid));
            @(negedge clk);
            ctrl.flush = 1'b0;
        end else begin
            miss = model_access(tbl_addr[i]);
            if (tbl_miss[i] >= 0 && miss != bit'(tbl_miss[i]))
                report($sformatf("entry %0d: model disagrees with table", i));
            while (!inst_valid) begin
                step();
                latency++;
            end
            if (inst !== expected_word(tbl_addr[i]))
                report($sformatf("entry %0d: inst %h, expected %h", i, inst,
                                 expected_word(tbl_addr[i])));
            if (!miss && (latency != 1 || req_count != count_before))
                report($sformatf("entry %0d: hit took %0d cycles", i, latency));
            if (miss && (latency == 1 || req_count != count_before + 1))
                report($sformatf("entry %0d: miss made %0d requests", i,
                                 req_count - count_before));
            if (miss && tbl_stall[i]) begin
                repeat (3) begin
                    step();
                    if (!inst_valid || inst !== expected_word(tbl_addr[i]))
                        report($sformatf("entry %0d: word lost during stall", i));
                end
                @(negedge clk);
                ctrl.stall = 1'b0;   // last cycle of replace
                #1;
                if (!inst_valid || inst !== expected_word(tbl_addr[i]))
                    report($sformatf("entry %0d: word lost as stall dropped", i));
            end
        end
    endtask

    initial begin
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_op       = 1'b0;
        ctrl         = '0;
        errors       = 0;
        checks       = 0;
        cycles       = 0;
        model_misses = 0;
        seed         = 32'd4481;
        for (int s = 0; s < 16; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        build_table();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        #1;
        checks++;
        if (req_ready) report("req_ready high in the first cycle after reset");
        for (int i = 0; i < N; i++) run_entry(i);
        repeat (2) @(negedge clk);
        checks++;
        if (req_count != model_misses)
            report($sformatf("memory requests %0d, model misses %0d", req_count, model_misses));
        $display("checks: %0d, errors: %0d, memory requests: %0d", checks, errors, req_count);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+source
source/icache_pkg.sv
source/icache_set_ram.sv
source/icache_req_buf.sv
source/icache_lru.sv
source/icache_hit_select.sv
source/icache_ctrl_fsm.sv
source/icache_top.sv
verification/icache_mem_model.sv
verification/icache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary -Wno-fatal -f compile.f --top-module icache_tb -o icache_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/icache_sim > sim.log 2>&1 || true
cat sim.log

grep -q "Test failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test completed successfully" sim.log || { echo "no pass line in log"; exit 1; }
exit 0
